// File: hdl/flit_widen_pkg.sv
// Flit width converter definitions

package flit_widen_pkg;

  // -------------------------------------------------------------------------
  // Widths
  // -------------------------------------------------------------------------

  // Narrow flit accepted on the input port
  localparam int PUSH_WIDTH = 8;
  // Wide word produced on the output port
  localparam int POP_WIDTH = 32;
  // Packet metadata sideband, passed through untouched
  localparam int META_WIDTH = 3;

  // Number of flits that fill one output word
  localparam int RATIO = POP_WIDTH / PUSH_WIDTH;
  // Wide enough for a slice index and for the don't-care count
  localparam int ID_WIDTH = $clog2(RATIO);

  // First flit of a word lands in the most-significant slice
  localparam bit MS_FIRST = 1'b1;

  // -------------------------------------------------------------------------
  // Payloads
  // -------------------------------------------------------------------------

  // One narrow flit with its packet markers
  typedef struct packed {
    logic [PUSH_WIDTH-1:0] data;
    logic                  last;
    logic [META_WIDTH-1:0] meta;
  } push_flit_t;

  // One rebuilt word, with the number of zero-filled tail slices
  typedef struct packed {
    logic [POP_WIDTH-1:0]  data;
    logic                  last;
    logic [ID_WIDTH-1:0]   dont_care_count;
    logic [META_WIDTH-1:0] meta;
  } pop_flit_t;

endpackage

// File: hdl/flit_flow_if.sv
// Ready/valid flow interface

`timescale 1ns/1ps

// A transfer happens on a clock edge that sees valid and ready both high.
// The source keeps valid and payload steady until that transfer
interface flit_flow_if #(
  parameter type payload_t = logic
);

  // Source has something to hand over
  logic     valid;
  // Sink can take it this cycle
  logic     ready;
  // Whatever the stage carries
  payload_t payload;

  // Producer side of the link
  modport source (
    output valid,
    output payload,
    input  ready
  );

  // Consumer side of the link
  modport sink (
    input  valid,
    input  payload,
    output ready
  );

endinterface

// File: hdl/flit_reg_slice.sv
// Skid register slice

`timescale 1ns/1ps

module flit_reg_slice #(
  parameter type payload_t = logic
) (
  input logic       clk,
  input logic       rst_n,
  flit_flow_if.sink   up,
  flit_flow_if.source dn
);

  // -------------------------------------------------------------------------
  // Storage
  // -------------------------------------------------------------------------

  // The main entry drives the output; the skid entry catches a value that
  // arrives while the main entry is stalled downstream
  logic     main_valid;
  logic     skid_valid;
  payload_t main_data;
  payload_t skid_data;

  logic up_xfer;
  logic dn_xfer;
  // Main entry is free to take a new value this cycle
  logic main_load;

  assign up_xfer   = up.valid && up.ready;
  assign dn_xfer   = dn.valid && dn.ready;
  assign main_load = !main_valid || dn_xfer;

  // Ready comes straight from a flop, so upstream never sees a combinational
  // path through this slice. It only drops once the skid entry holds data,
  // which means both entries are full
  assign up.ready = !skid_valid;

  assign dn.valid   = main_valid;
  assign dn.payload = main_data;

  // -------------------------------------------------------------------------
  // Control
  // -------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (main_load) begin
      // Skid drains first so ordering is kept
      if (skid_valid) begin
        main_valid <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        main_valid <= up_xfer;
      end
    end else if (up_xfer) begin
      // Main is stalled, park the new value
      skid_valid <= 1'b1;
    end
  end

  // Payload registers follow the same selection as the valid bits
  always_ff @(posedge clk) begin
    if (main_load) begin
      if (skid_valid) begin
        main_data <= skid_data;
      end else if (up_xfer) begin
        main_data <= up.payload;
      end
    end else if (up_xfer) begin
      skid_data <= up.payload;
    end
  end

  // A stalled output word must be presented unchanged on the next cycle
  dn_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (dn.valid && !dn.ready) |=> (dn.valid && $stable(dn.payload)));

endmodule

// File: hdl/flit_deserializer.sv
// Narrow to wide flit deserializer

`timescale 1ns/1ps

module flit_deserializer (
  input logic       clk,
  input logic       rst_n,
  flit_flow_if.sink   push,
  flit_flow_if.source pop
);

  // Index of the final slice in a word
  localparam logic [flit_widen_pkg::ID_WIDTH-1:0] LAST_IDX =
    flit_widen_pkg::ID_WIDTH'(flit_widen_pkg::RATIO - 1);

  // -------------------------------------------------------------------------
  // Handshake and slice index
  // -------------------------------------------------------------------------

  // Slice that the flit at the input belongs to
  logic [flit_widen_pkg::ID_WIDTH-1:0] idx;

  logic push_fire;
  logic pop_fire;
  // Flit at the input closes the current word
  logic completing;

  assign completing = push.payload.last || (idx == LAST_IDX);
  assign push_fire  = push.valid && push.ready;
  assign pop_fire   = pop.valid && pop.ready;

  // Early flits are always taken since they only go into staging.
  // The completing flit waits until the word can leave, so the upstream
  // slice keeps holding it
  assign push.ready = !completing || pop.ready;

  // The word is complete in the same cycle its closing flit shows up
  assign pop.valid = push.valid && completing;

  // Counter restarts on every popped word; otherwise it steps per flit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idx <= '0;
    end else if (pop_fire) begin
      idx <= '0;
    end else if (push_fire) begin
      idx <= idx + 1'b1;
    end
  end

  // -------------------------------------------------------------------------
  // Staging registers
  // -------------------------------------------------------------------------

  // One entry per slice except the last, which never needs holding
  logic [flit_widen_pkg::RATIO-2:0][flit_widen_pkg::PUSH_WIDTH-1:0] stage;

  // Demux by index. A non-completing flit never has idx at LAST_IDX
  always_ff @(posedge clk) begin
    if (push_fire && !completing) begin
      stage[idx] <= push.payload.data;
    end
  end

  // -------------------------------------------------------------------------
  // Word assembly
  // -------------------------------------------------------------------------

  logic [flit_widen_pkg::RATIO-1:0][flit_widen_pkg::PUSH_WIDTH-1:0] slice_val;
  logic [flit_widen_pkg::POP_WIDTH-1:0] word_data;
  flit_widen_pkg::pop_flit_t            pop_word;

  for (genvar i = 0; i < flit_widen_pkg::RATIO; i++) begin : g_slice
    // Slice 0 sits at the top of the word when the stream is MS first
    localparam int LSB = flit_widen_pkg::MS_FIRST ?
      (flit_widen_pkg::RATIO - 1 - i) * flit_widen_pkg::PUSH_WIDTH :
      i * flit_widen_pkg::PUSH_WIDTH;

    if (i < flit_widen_pkg::RATIO - 1) begin : g_staged
      // Earlier slices come from staging, the current one passes through,
      // and anything past the index is zero filled
      assign slice_val[i] =
        (flit_widen_pkg::ID_WIDTH'(i) < idx)  ? stage[i] :
        (flit_widen_pkg::ID_WIDTH'(i) == idx) ? push.payload.data :
        '0;
    end else begin : g_tail
      // Last slice only ever holds the flit that fills the word
      assign slice_val[i] = (idx == LAST_IDX) ? push.payload.data : '0;
    end

    assign word_data[LSB +: flit_widen_pkg::PUSH_WIDTH] = slice_val[i];
  end

  // Sideband fields are sampled from the completing flit
  always_comb begin
    pop_word.data            = word_data;
    pop_word.last            = push.payload.last;
    pop_word.dont_care_count = LAST_IDX - idx;
    pop_word.meta            = push.payload.meta;
  end

  assign pop.payload = pop_word;

  // -------------------------------------------------------------------------
  // Checks
  // -------------------------------------------------------------------------

  // Output only exists while its completing flit is on the input
  pop_needs_push_a: assert property (@(posedge clk) disable iff (!rst_n)
    pop.valid |-> push.valid);

  // Short words only happen at the end of a packet
  short_word_a: assert property (@(posedge clk) disable iff (!rst_n)
    (pop.valid && idx != LAST_IDX) |->
      (pop.payload.last && pop.payload.dont_care_count != '0));

  // Staging relies on the upstream stage holding a refused flit
  push_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (push.valid && !push.ready) |=> (push.valid && $stable(push.payload)));

endmodule

// File: hdl/flit_widen_top.sv
// Flit widener top level

`timescale 1ns/1ps

module flit_widen_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  // Narrow flit input
  input  logic                                  in_valid,
  output logic                                  in_ready,
  input  logic [flit_widen_pkg::PUSH_WIDTH-1:0] in_data,
  input  logic                                  in_last,
  input  logic [flit_widen_pkg::META_WIDTH-1:0] in_meta,
  // Wide word output
  output logic                                  out_valid,
  input  logic                                  out_ready,
  output logic [flit_widen_pkg::POP_WIDTH-1:0]  out_data,
  output logic                                  out_last,
  output logic [flit_widen_pkg::ID_WIDTH-1:0]   out_dont_care_count,
  output logic [flit_widen_pkg::META_WIDTH-1:0] out_meta
);

  // -------------------------------------------------------------------------
  // Links between the stages
  // -------------------------------------------------------------------------

  // Boundary links that bundle the plain ports
  flit_flow_if #(.payload_t(flit_widen_pkg::push_flit_t)) in_port ();
  flit_flow_if #(.payload_t(flit_widen_pkg::pop_flit_t))  out_port ();

  // Internal links on either side of the deserializer
  flit_flow_if #(.payload_t(flit_widen_pkg::push_flit_t)) in_flow ();
  flit_flow_if #(.payload_t(flit_widen_pkg::pop_flit_t))  out_flow ();

  // Pack the input pins
  assign in_port.valid        = in_valid;
  assign in_port.payload.data = in_data;
  assign in_port.payload.last = in_last;
  assign in_port.payload.meta = in_meta;
  assign in_ready             = in_port.ready;

  // Unpack onto the output pins
  assign out_valid           = out_port.valid;
  assign out_data            = out_port.payload.data;
  assign out_last            = out_port.payload.last;
  assign out_dont_care_count = out_port.payload.dont_care_count;
  assign out_meta            = out_port.payload.meta;
  assign out_port.ready      = out_ready;

  // -------------------------------------------------------------------------
  // Pipeline
  // -------------------------------------------------------------------------

  // Holds each flit steady until the deserializer takes it
  flit_reg_slice #(.payload_t(flit_widen_pkg::push_flit_t)) u_ingress (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (in_port.sink),
    .dn    (in_flow.source)
  );

  flit_deserializer u_deser (
    .clk   (clk),
    .rst_n (rst_n),
    .push  (in_flow.sink),
    .pop   (out_flow.source)
  );

  // Cuts the combinational ready path from out_ready
  flit_reg_slice #(.payload_t(flit_widen_pkg::pop_flit_t)) u_egress (
    .clk   (clk),
    .rst_n (rst_n),
    .up    (out_flow.sink),
    .dn    (out_port.source)
  );

endmodule

// File: sim/flit_widen_tb.sv
// Flit widener testbench

`timescale 1ns/1ps

module flit_widen_tb;

  // Cycles that any single wait may take before the run is abandoned
  localparam int WAIT_LIMIT = 2000;
  localparam int EXP_DEPTH = 1024;
  localparam logic [31:0] SEED = 32'hc61c_91f0;

  logic clk = 1'b0;
  logic rst_n = 1'b0;
  logic in_valid;
  logic in_ready;
  logic [flit_widen_pkg::PUSH_WIDTH-1:0] in_data;
  logic in_last;
  logic [flit_widen_pkg::META_WIDTH-1:0] in_meta;
  logic out_valid;
  logic out_ready = 1'b1;
  logic [flit_widen_pkg::POP_WIDTH-1:0] out_data;
  logic out_last;
  logic [flit_widen_pkg::ID_WIDTH-1:0] out_dont_care_count;
  logic [flit_widen_pkg::META_WIDTH-1:0] out_meta;

  // Separate LFSR streams for the input side and for out_ready stalls
  logic [31:0] stim_lfsr = SEED;
  logic [31:0] stall_lfsr = SEED;
  string test_name = "reset";
  // High while the driven flit closes a word
  logic in_completes = 1'b0;
  logic lat_mode = 1'b0;
  logic stall_mode = 1'b0;
  logic gaps_on = 1'b0;

  // Expected words in order of arrival
  flit_widen_pkg::pop_flit_t exp_mem [EXP_DEPTH];
  int wr_ptr = 0;
  int rd_ptr = 0;
  int pending;
  flit_widen_pkg::pop_flit_t exp_head;
  flit_widen_pkg::pop_flit_t out_word;
  // Completing flits accepted one and two cycles ago
  logic [1:0] comp_pipe = 2'b00;
  logic comp_seen = 1'b0;
  int shapes [10] = '{4, 8, 1, 2, 3, 5, 6, 7, 12, 9};

  always #20 clk = ~clk;

  flit_widen_top i_flit_widen_top (
    .clk                 (clk),
    .rst_n               (rst_n),
    .in_valid            (in_valid),
    .in_ready            (in_ready),
    .in_data             (in_data),
    .in_last             (in_last),
    .in_meta             (in_meta),
    .out_valid           (out_valid),
    .out_ready           (out_ready),
    .out_data            (out_data),
    .out_last            (out_last),
    .out_dont_care_count (out_dont_care_count),
    .out_meta            (out_meta)
  );

  assign pending  = wr_ptr - rd_ptr;
  assign exp_head = exp_mem[rd_ptr];
  assign out_word = '{data: out_data, last: out_last,
                      dont_care_count: out_dont_care_count, meta: out_meta};

  // ------------------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------------------

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic idle(input int n);
    in_valid = 1'b0;
    in_completes = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // Holds the flit until the edge that takes it; in_ready only moves on a rising edge
  task automatic send_flit(input logic [flit_widen_pkg::PUSH_WIDTH-1:0] data,
                           input logic                                  last,
                           input logic [flit_widen_pkg::META_WIDTH-1:0] meta,
                           input logic                                  completes);
    logic was_ready;
    int waited;
    was_ready = 1'b0;
    waited = 0;
    in_valid = 1'b1;
    in_data = data;
    in_last = last;
    in_meta = meta;
    in_completes = completes;
    while (!was_ready) begin
      if (waited > WAIT_LIMIT) begin
        abort_run("timed out waiting for in_ready");
      end else begin
        was_ready = in_ready;
        @(negedge clk);
        waited++;
      end
    end
  endtask

  // Builds each expected word MS slice first, zero filled past the last flit
  task automatic send_packet(input int len);
    flit_widen_pkg::pop_flit_t word;
    logic [flit_widen_pkg::PUSH_WIDTH-1:0] data;
    logic [flit_widen_pkg::META_WIDTH-1:0] meta;
    logic last;
    logic completes;
    int slot;
    word = '0;
    for (int i = 0; i < len; i++) begin
      data = flit_widen_pkg::PUSH_WIDTH'(take_bits(flit_widen_pkg::PUSH_WIDTH));
      meta = flit_widen_pkg::META_WIDTH'(take_bits(flit_widen_pkg::META_WIDTH));
      slot = i % flit_widen_pkg::RATIO;
      last = (i == len - 1);
      completes = last || (slot == flit_widen_pkg::RATIO - 1);
      if (slot == 0) begin
        word = '0;
      end
      word.data[flit_widen_pkg::POP_WIDTH - 1 - slot * flit_widen_pkg::PUSH_WIDTH
                -: flit_widen_pkg::PUSH_WIDTH] = data;
      if (completes) begin
        word.last = last;
        word.dont_care_count = flit_widen_pkg::ID_WIDTH'(flit_widen_pkg::RATIO - 1 - slot);
        word.meta = meta;
        exp_mem[wr_ptr] = word;
        wr_ptr = wr_ptr + 1;
      end
      send_flit(data, last, meta, completes);
      if (gaps_on) begin
        idle(take_bits(1) ? int'(take_bits(2)) : 0);
      end
    end
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    idle(0);
    while (pending != 0) begin
      if (waited > WAIT_LIMIT) begin
        abort_run("timed out waiting for the expected words");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
    // A few idle cycles so a stray extra word would still be caught
    idle(4);
  endtask

  // ------------------------------------------------------------------------
  // Monitors and checks
  // ------------------------------------------------------------------------

  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      rd_ptr <= rd_ptr + 1;
    end
    if (rst_n && in_valid && in_ready && in_completes) begin
      comp_seen <= 1'b1;
    end
    comp_pipe <= {comp_pipe[0], lat_mode && in_valid && in_ready && in_completes};
  end

  // out_ready toggles at random only in the stall phase
  always @(negedge clk) begin
    if (stall_mode) begin
      stall_lfsr = lfsr_next(stall_lfsr);
      out_ready = stall_lfsr[0];
    end else begin
      out_ready = 1'b1;
    end
  end

  quiet_a: assert property (@(posedge clk) !comp_seen |-> !out_valid)
    else abort_run("out_valid went high before any word was complete");

  ready_a: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
    else abort_run("in_ready was low on the first cycle after reset");

  expected_a: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready) |-> pending != 0)
    else abort_run("an output word arrived that no packet produced");

  word_a: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && out_ready && pending != 0) |-> out_word == exp_head)
    else abort_run($sformatf("MISMATCH %s expected %h actual %h",
                             test_name, $sampled(exp_head), $sampled(out_word)));

  hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_word)))
    else abort_run("output word changed while out_ready was low");

  latency_a: assert property (@(posedge clk) disable iff (!rst_n)
    comp_pipe[1] |-> out_valid)
    else abort_run("word was not valid two cycles after its completing flit");

  // ------------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------------

  initial begin
    in_valid = 1'b0;
    in_data = '0;
    in_last = 1'b0;
    in_meta = '0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Every packet shape with a free-running output
    test_name = "word_shapes";
    lat_mode = 1'b1;
    foreach (shapes[i]) begin
      send_packet(shapes[i]);
    end
    drain();
    lat_mode = 1'b0;

    test_name = "back_pressure";
    stall_mode = 1'b1;
    gaps_on = 1'b1;
    repeat (40) begin
      send_packet(int'(take_bits(4)) + 1);
    end
    drain();
    stall_mode = 1'b0;

    if (pending == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run("expected words are still outstanding at the end");
    end
  end

endmodule

// File: flit_widen.f
hdl/flit_widen_pkg.sv
hdl/flit_flow_if.sv
hdl/flit_reg_slice.sv
hdl/flit_deserializer.sv
hdl/flit_widen_top.sv
sim/flit_widen_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module flit_widen_tb -f flit_widen.f || exit 1
./obj_dir/Vflit_widen_tb > sim.log 2>&1 || echo "TEST FAILED" >> sim.log
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1
exit 0
